// ==== hdl/audio_mix_top.sv ====
`timescale 1ns/1ns

// audio mix path
// formatter -> frame fifo -> mixer
module audio_mix_top
	import audio_sample_pkg::*;
	import mix_link_pkg::*;
#(
	parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
	input  logic             clk_sys,
	input  logic             reset,

	// input frame port
	input  logic             in_req,
	output logic             in_ack,
	input  logic [PCM_W-1:0] paula_pcm_l,
	input  logic [PCM_W-1:0] paula_pcm_r,
	input  logic [PWM_W-1:0] paula_pwm_l,
	input  logic [PWM_W-1:0] paula_pwm_r,
	input  sample_t          cdda_l,
	input  sample_t          cdda_r,
	input  sample_t          synth_l,
	input  sample_t          synth_r,
	input  logic             paula_pwm,  // sampled with the frame
	input  logic             synth_mute, // sampled with the frame

	// mixed output port
	output logic             out_req,
	input  logic             out_ack,
	output sample_t          out_l,
	output sample_t          out_r
);

	mix_link_if fmt_link ();
	mix_link_if mix_link ();

	sample_formatter u_formatter (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.in_req     (in_req),
		.in_ack     (in_ack),
		.paula_pcm_l(paula_pcm_l),
		.paula_pcm_r(paula_pcm_r),
		.paula_pwm_l(paula_pwm_l),
		.paula_pwm_r(paula_pwm_r),
		.cdda_l     (cdda_l),
		.cdda_r     (cdda_r),
		.synth_l    (synth_l),
		.synth_r    (synth_r),
		.paula_pwm  (paula_pwm),
		.synth_mute (synth_mute),
		.out_link   (fmt_link.sender)
	);

	frame_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk_sys (clk_sys),
		.reset   (reset),
		.in_link (fmt_link.receiver),
		.out_link(mix_link.sender)
	);

	stereo_mixer u_mixer (
		.clk_sys(clk_sys),
		.reset  (reset),
		.in_link(mix_link.receiver),
		.out_req(out_req),
		.out_ack(out_ack),
		.out_l  (out_l),
		.out_r  (out_r)
	);

endmodule

// ==== hdl/audio_sample_pkg.sv ====
package audio_sample_pkg;

	// mixed output and cd / synth sources
	localparam int SAMPLE_W = 16;

	// paula dac forms
	localparam int PCM_W = 15; // plain pcm value
	localparam int PWM_W = 9;  // pwm-volume value

	// left shift that lifts each paula form to a full sample
	localparam int PCM_SHIFT = SAMPLE_W - PCM_W;
	localparam int PWM_SHIFT = SAMPLE_W - PWM_W;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// one sample per channel
	typedef struct packed {
		sample_t l;
		sample_t r;
	} stereo_t;

	// everything the mixer needs for one output frame
	typedef struct packed {
		stereo_t paula; // already formatted to SAMPLE_W
		stereo_t cdda;
		stereo_t synth; // zero when muted
	} mix_frame_t;

	localparam int FRAME_W = $bits(mix_frame_t); // 96

endpackage

// ==== hdl/frame_fifo.sv ====
`timescale 1ns/1ns

// circular buffer of mix frames between two four-phase links
module frame_fifo
	import audio_sample_pkg::*;
	import mix_link_pkg::*;
#(
	parameter int FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
	input  logic         clk_sys,
	input  logic         reset,
	mix_link_if.receiver in_link,
	mix_link_if.sender   out_link
);

	localparam int AW = $clog2(FIFO_DEPTH);

	mix_frame_t    mem [FIFO_DEPTH];
	mix_frame_t    head;
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          empty;
	logic          push;
	logic          pop;
	logic          in_ack;
	logic          out_req;
	link_state_t   state;

	assign full  = (count == (AW+1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// new frame only when there is room, ack stays low while full
	assign push = in_link.req && !in_ack && !full;
	assign pop  = (state == wait_ack) && out_link.ack;

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= '{paula: in_link.paula, cdda: in_link.cdda, synth: in_link.synth};
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			in_ack  <= 1'b0;
			out_req <= 1'b0;
			state   <= idle;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase

			if (push)
				in_ack <= 1'b1;
			else if (in_ack && !in_link.req)
				in_ack <= 1'b0;

			case (state)
				idle: begin
					if (!empty) begin
						out_req <= 1'b1;
						state   <= wait_ack;
					end
				end
				wait_ack: begin
					if (out_link.ack) begin
						out_req <= 1'b0;
						state   <= wait_release;
					end
				end
				wait_release: begin
					// re-arm straight away if more is queued
					if (!out_link.ack) begin
						out_req <= !empty;
						state   <= empty ? idle : wait_ack;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// head slot is never written while offered
	assign head = mem[rd_ptr];

	assign in_link.ack    = in_ack;
	assign out_link.req   = out_req;
	assign out_link.paula = head.paula;
	assign out_link.cdda  = head.cdda;
	assign out_link.synth = head.synth;

endmodule

// ==== hdl/mix_link_if.sv ====
`timescale 1ns/1ns

// four-phase frame link
// data is stable before req rises and stays so until ack is seen
interface mix_link_if
	import audio_sample_pkg::*;
();
	logic    req;
	logic    ack;
	stereo_t paula;
	stereo_t cdda;
	stereo_t synth;

	modport sender (
		output req,
		output paula,
		output cdda,
		output synth,
		input  ack
	);

	modport receiver (
		input  req,
		input  paula,
		input  cdda,
		input  synth,
		output ack
	);

endinterface

// ==== hdl/mix_link_pkg.sv ====
package mix_link_pkg;

	// sender side of a four-phase req/ack link
	// idle          req low, may raise it
	// wait_ack      req high, data held
	// wait_release  req dropped, waiting for ack low
	typedef enum logic [1:0] {
		idle,
		wait_ack,
		wait_release
	} link_state_t;

	// frames buffered between formatter and mixer
	localparam int DEFAULT_FIFO_DEPTH = 4;

endpackage

// ==== hdl/sample_formatter.sv ====
`timescale 1ns/1ns

// captures one input frame, formats paula, applies synth mute
// and hands the frame to the fifo over a four-phase link
module sample_formatter
	import audio_sample_pkg::*;
	import mix_link_pkg::*;
(
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             in_req,
	output logic             in_ack,
	input  logic [PCM_W-1:0] paula_pcm_l,
	input  logic [PCM_W-1:0] paula_pcm_r,
	input  logic [PWM_W-1:0] paula_pwm_l,
	input  logic [PWM_W-1:0] paula_pwm_r,
	input  sample_t          cdda_l,
	input  sample_t          cdda_r,
	input  sample_t          synth_l,
	input  sample_t          synth_r,
	input  logic             paula_pwm,
	input  logic             synth_mute,
	mix_link_if.sender       out_link
);

	link_state_t state;
	mix_frame_t  frame_d;
	mix_frame_t  frame_q;
	logic        link_req;
	logic        capture;

	// pcm gets one zero bit below, pwm-volume gets seven
	function automatic sample_t fmt_paula(
		input logic [PCM_W-1:0] pcm,
		input logic [PWM_W-1:0] pwm,
		input logic             pwm_mode
	);
		logic [SAMPLE_W-1:0] pcm_ext;
		logic [SAMPLE_W-1:0] pwm_ext;
		pcm_ext = SAMPLE_W'(pcm) << PCM_SHIFT;
		pwm_ext = SAMPLE_W'(pwm) << PWM_SHIFT;
		return pwm_mode ? sample_t'(pwm_ext) : sample_t'(pcm_ext);
	endfunction

	// input side idle and holding register free
	assign capture = in_req && !in_ack && (state == idle);

	always_comb begin
		frame_d.paula.l = fmt_paula(paula_pcm_l, paula_pwm_l, paula_pwm);
		frame_d.paula.r = fmt_paula(paula_pcm_r, paula_pwm_r, paula_pwm);
		frame_d.cdda.l  = cdda_l;
		frame_d.cdda.r  = cdda_r;
		frame_d.synth.l = synth_mute ? '0 : synth_l;
		frame_d.synth.r = synth_mute ? '0 : synth_r;
	end

	always_ff @(posedge clk_sys) begin
		if (capture)
			frame_q <= frame_d;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			in_ack   <= 1'b0;
			link_req <= 1'b0;
			state    <= idle;
		end else begin
			if (capture)
				in_ack <= 1'b1;
			else if (in_ack && !in_req)
				in_ack <= 1'b0; // producer released

			case (state)
				idle: begin
					if (capture) begin
						link_req <= 1'b1;
						state    <= wait_ack;
					end
				end
				wait_ack: begin
					if (out_link.ack) begin
						link_req <= 1'b0;
						state    <= wait_release;
					end
				end
				wait_release: begin
					if (!out_link.ack)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	assign out_link.req   = link_req;
	assign out_link.paula = frame_q.paula;
	assign out_link.cdda  = frame_q.cdda;
	assign out_link.synth = frame_q.synth;

endmodule

// ==== hdl/stereo_mixer.sv ====
`timescale 1ns/1ns

// sums paula, cd and synth per channel, clamps to 16 bits
// and presents the result on the output four-phase port
module stereo_mixer
	import audio_sample_pkg::*;
	import mix_link_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	mix_link_if.receiver in_link,
	output logic         out_req,
	input  logic         out_ack,
	output sample_t      out_l,
	output sample_t      out_r
);

	link_state_t state;
	logic        in_ack;
	logic        sum_valid; // sums registered, out_req not yet raised
	logic        take;

	// 17-bit sum, saturate when the top two bits disagree
	function automatic sample_t mix_clamp(
		input sample_t a,
		input sample_t b,
		input sample_t c
	);
		logic [SAMPLE_W:0] sum;
		sum = {a[SAMPLE_W-1], a} + {b[SAMPLE_W-1], b} + {c[SAMPLE_W-1], c};
		if (sum[SAMPLE_W] ^ sum[SAMPLE_W-1])
			return {sum[SAMPLE_W], {(SAMPLE_W-1){sum[SAMPLE_W-1]}}};
		return sum[SAMPLE_W-1:0];
	endfunction

	// output must be fully released before the next frame
	assign take = in_link.req && !in_ack && !sum_valid && (state == idle);

	always_ff @(posedge clk_sys) begin
		if (take) begin
			out_l <= mix_clamp(in_link.paula.l, in_link.cdda.l, in_link.synth.l);
			out_r <= mix_clamp(in_link.paula.r, in_link.cdda.r, in_link.synth.r);
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			in_ack    <= 1'b0;
			sum_valid <= 1'b0;
			out_req   <= 1'b0;
			state     <= idle;
		end else begin
			if (take)
				in_ack <= 1'b1;
			else if (in_ack && !in_link.req)
				in_ack <= 1'b0;

			if (take)
				sum_valid <= 1'b1;

			case (state)
				idle: begin
					if (sum_valid) begin
						sum_valid <= 1'b0;
						out_req   <= 1'b1;
						state     <= wait_ack;
					end
				end
				wait_ack: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state   <= wait_release;
					end
				end
				wait_release: begin
					if (!out_ack)
						state <= idle; // out_l / out_r free again
				end
				default: state <= idle;
			endcase
		end
	end

	assign in_link.ack = in_ack;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the audio mix testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/sim_audio_mix

verilator --binary --timing -Wno-fatal \
	--top-module tb_audio_mix \
	-f vlog.f \
	-o sim_audio_mix > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "build failed"
	exit 1
fi

"$SIM_BIN" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^Everything OK$" "$SIM_LOG"; then
	exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

// ==== verif/tb_audio_model.svh ====
`ifndef TB_AUDIO_MODEL_SVH
`define TB_AUDIO_MODEL_SVH

// stimulus generator, reference model and value check
// included inside the testbench module

logic [31:0] lcg_state = 32'hcf9e;
logic [31:0] exp_q[$]; // expected {left, right} per frame, oldest first

function automatic logic [31:0] next_random();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// paula value as a 16-bit sample
function automatic logic [15:0] paula_expect(
	input logic [PCM_W-1:0] pcm,
	input logic [PWM_W-1:0] pwm,
	input logic             pwm_mode
);
	if (pwm_mode)
		return {pwm, 7'b0000000}; // volume value in the top nine bits
	return {pcm, 1'b0};
endfunction

// 17-bit sum of three sources, limited to the 16-bit range
function automatic logic [15:0] mix_expect(
	input logic [15:0] a,
	input logic [15:0] b,
	input logic [15:0] c
);
	int s;
	s = $signed(a) + $signed(b) + $signed(c);
	s = $signed(s[16:0]); // mixer adds at 17 bits
	if (s > 32767)
		return 16'h7fff;
	if (s < -32768)
		return 16'h8000;
	return s[15:0];
endfunction

task automatic expect_frame(
	input logic [PCM_W-1:0] pcm_l,
	input logic [PCM_W-1:0] pcm_r,
	input logic [PWM_W-1:0] pwm_l,
	input logic [PWM_W-1:0] pwm_r,
	input logic [15:0]      cd_l,
	input logic [15:0]      cd_r,
	input logic [15:0]      syn_l,
	input logic [15:0]      syn_r,
	input logic             pwm_mode,
	input logic             mute
);
	logic [15:0] pl;
	logic [15:0] pr;
	logic [15:0] sl;
	logic [15:0] sr;
	pl = paula_expect(pcm_l, pwm_l, pwm_mode);
	pr = paula_expect(pcm_r, pwm_r, pwm_mode);
	sl = mute ? 16'h0000 : syn_l;
	sr = mute ? 16'h0000 : syn_r;
	exp_q.push_back({mix_expect(pl, cd_l, sl), mix_expect(pr, cd_r, sr)});
endtask

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("MISMATCH %s got 0x%h expected 0x%h", what, got, exp);
		fail_now("value check failed");
	end
endtask

`endif

// ==== verif/tb_audio_mix.sv ====
`timescale 1ns/1ns

// testbench for the audio mix path
module tb_audio_mix
	import audio_sample_pkg::*;
();

	localparam int FIFO_DEPTH = 4;
	localparam int TIMEOUT    = 500; // cycles allowed per wait

	logic             clk_sys;
	logic             reset;
	logic             in_req;
	logic             in_ack;
	logic [PCM_W-1:0] paula_pcm_l;
	logic [PCM_W-1:0] paula_pcm_r;
	logic [PWM_W-1:0] paula_pwm_l;
	logic [PWM_W-1:0] paula_pwm_r;
	logic [15:0]      cdda_l;
	logic [15:0]      cdda_r;
	logic [15:0]      synth_l;
	logic [15:0]      synth_r;
	logic             paula_pwm;
	logic             synth_mute;
	logic             out_req;
	logic             out_ack;
	logic [15:0]      out_l;
	logic [15:0]      out_r;
	int               max_ack_wait; // longest in_ack wait in cycles

	audio_mix_top #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_audio_mix_top (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.in_req     (in_req),
		.in_ack     (in_ack),
		.paula_pcm_l(paula_pcm_l),
		.paula_pcm_r(paula_pcm_r),
		.paula_pwm_l(paula_pwm_l),
		.paula_pwm_r(paula_pwm_r),
		.cdda_l     (cdda_l),
		.cdda_r     (cdda_r),
		.synth_l    (synth_l),
		.synth_r    (synth_r),
		.paula_pwm  (paula_pwm),
		.synth_mute (synth_mute),
		.out_req    (out_req),
		.out_ack    (out_ack),
		.out_l      (out_l),
		.out_r      (out_r)
	);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	`include "tb_audio_model.svh"

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_in_ack(input logic level, output int cycles);
		cycles = 0;
		while (in_ack !== level) begin
			if (cycles >= TIMEOUT)
				fail_now("timed out waiting for in_ack to change");
			else begin
				next_cycle();
				cycles++;
			end
		end
	endtask

	task automatic wait_out_req(input logic level);
		int cycles;
		cycles = 0;
		while (out_req !== level) begin
			if (cycles >= TIMEOUT)
				fail_now("timed out waiting for out_req to change");
			else begin
				next_cycle();
				cycles++;
			end
		end
	endtask

	task automatic send_frame(
		input logic [PCM_W-1:0] pcm_l,
		input logic [PCM_W-1:0] pcm_r,
		input logic [PWM_W-1:0] pwm_l,
		input logic [PWM_W-1:0] pwm_r,
		input logic [15:0]      cd_l,
		input logic [15:0]      cd_r,
		input logic [15:0]      syn_l,
		input logic [15:0]      syn_r,
		input logic             pwm_mode,
		input logic             mute
	);
		int waited;
		expect_frame(pcm_l, pcm_r, pwm_l, pwm_r, cd_l, cd_r, syn_l, syn_r, pwm_mode, mute);
		paula_pcm_l = pcm_l;
		paula_pcm_r = pcm_r;
		paula_pwm_l = pwm_l;
		paula_pwm_r = pwm_r;
		cdda_l      = cd_l;
		cdda_r      = cd_r;
		synth_l     = syn_l;
		synth_r     = syn_r;
		paula_pwm   = pwm_mode;
		synth_mute  = mute;
		in_req      = 1'b1;
		wait_in_ack(1'b1, waited);
		if (waited > max_ack_wait)
			max_ack_wait = waited;
		in_req = 1'b0;
		wait_in_ack(1'b0, waited);
	endtask

	task automatic send_random(input logic pwm_mode, input logic mute);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		r0 = next_random();
		r1 = next_random();
		r2 = next_random();
		r3 = next_random();
		send_frame(r0[30:16], r1[30:16], r0[8:0], r1[8:0],
			r2[31:16], r3[31:16], r2[15:0], r3[15:0], pwm_mode, mute);
	endtask

	task automatic receive_frame(input int ack_delay);
		logic [31:0] exp;
		wait_out_req(1'b1);
		if (exp_q.size() == 0)
			fail_now("output frame arrived with no frame expected");
		else begin
			exp = exp_q.pop_front();
			check_value("out_l", {16'h0000, out_l}, {16'h0000, exp[31:16]});
			check_value("out_r", {16'h0000, out_r}, {16'h0000, exp[15:0]});
			repeat (ack_delay) next_cycle();
			check_value("out_l held", {16'h0000, out_l}, {16'h0000, exp[31:16]});
			check_value("out_r held", {16'h0000, out_r}, {16'h0000, exp[15:0]});
			out_ack = 1'b1;
			wait_out_req(1'b0);
			out_ack = 1'b0;
		end
	endtask

	// delays drawn before the fork so the random sequence is fixed
	task automatic run_batch(input int n, input logic pwm_mode, input logic mute,
		input logic slow);
		int delays[$];
		for (int i = 0; i < n; i++) begin
			if (!slow)
				delays.push_back(0);
			else if (i == 0 || i % 8 == 7)
				delays.push_back(60); // long stall, fifo fills up
			else
				delays.push_back(int'(next_random() >> 28));
		end
		fork
			begin
				repeat (n) send_random(pwm_mode, mute);
			end
			begin
				for (int i = 0; i < n; i++)
					receive_frame(delays[i]);
			end
		join
	endtask

	initial begin
		reset        = 1'b1;
		in_req       = 1'b0;
		paula_pcm_l  = '0;
		paula_pcm_r  = '0;
		paula_pwm_l  = '0;
		paula_pwm_r  = '0;
		cdda_l       = '0;
		cdda_r       = '0;
		synth_l      = '0;
		synth_r      = '0;
		paula_pwm    = 1'b0;
		synth_mute   = 1'b0;
		out_ack      = 1'b0;
		max_ack_wait = 0;
		repeat (3) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// quiet after reset
		repeat (5) begin
			next_cycle();
			check_value("in_ack", 32'(in_ack), 32'h0);
			check_value("out_req", 32'(out_req), 32'h0);
		end

		run_batch(16, 1'b0, 1'b0, 1'b0); // pcm
		run_batch(16, 1'b1, 1'b0, 1'b0); // pwm-volume
		run_batch(12, 1'b0, 1'b1, 1'b0); // synth muted
		run_batch(12, 1'b1, 1'b1, 1'b0);

		// full scale on both sides, both signs
		fork
			begin
				send_frame(15'h3fff, 15'h4000, 9'h000, 9'h000,
					16'h7fff, 16'h8000, 16'h7fff, 16'h8000, 1'b0, 1'b0);
				send_frame(15'h0000, 15'h0000, 9'h100, 9'h0ff,
					16'h8000, 16'h7fff, 16'h8000, 16'h7fff, 1'b1, 1'b0);
			end
			begin
				receive_frame(0);
				receive_frame(0);
			end
		join

		// slow consumer
		max_ack_wait = 0;
		run_batch(32, 1'b0, 1'b0, 1'b1);
		check_value("in_ack stalled", 32'(max_ack_wait > 20), 32'h1);

		// no frame comes out twice
		repeat (20) begin
			next_cycle();
			check_value("out_req", 32'(out_req), 32'h0);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+verif
hdl/audio_sample_pkg.sv
hdl/mix_link_pkg.sv
hdl/mix_link_if.sv
hdl/sample_formatter.sv
hdl/frame_fifo.sv
hdl/stereo_mixer.sv
hdl/audio_mix_top.sv
verif/tb_audio_mix.sv
